/* hw/sssp_defs.svh */
`ifndef SSSP_DEFS_SVH
`define SSSP_DEFS_SVH

// memory and task word geometry
`define SSSP_WORD_W      32
`define SSSP_ADDR_W      32

// one response line is 64 bytes
`define SSSP_LINE_W      512
`define SSSP_LINE_WORDS  16

// pool sizes
`define SSSP_LOG_THREADS 2
`define SSSP_LOG_ARIDS   3

// an edge entry is neighbour word + weight word
`define SSSP_EDGE_WORDS  2

`endif

/* hw/sssp_pkg.sv */
`include "sssp_defs.svh"

package sssp_pkg;

   typedef struct packed {
      logic [`SSSP_WORD_W-1:0] ts;
      logic [`SSSP_WORD_W-1:0] vertex;
   } task_t;

   typedef struct packed {
      task_t                   task_desc;
      logic [`SSSP_WORD_W-1:0] eo_begin;
      logic [`SSSP_WORD_W-1:0] eo_end;   // exclusive
   } parent_t;

   typedef logic [`SSSP_LOG_THREADS-1:0] thread_id_t;
   typedef logic [`SSSP_LOG_ARIDS-1:0]   arid_t;

   typedef struct packed {
      thread_id_t                  thread;
      logic [`SSSP_LINE_WORDS-1:0] valid_words;
   } rd_rec_t;

   typedef struct packed {
      logic    valid;
      arid_t   id;
      rd_rec_t rec;
   } rd_rec_wr_t;

   typedef struct packed {
      logic       valid;
      thread_id_t thread;
      task_t      parent_task;
      logic [7:0] n_words;   // words still to be read for this parent
   } thread_alloc_t;

   typedef struct packed {
      task_t child_task;
      logic  last;
   } child_t;

   typedef enum logic [7:0] {
      CFG_NEIGHBOR_BASE = 8'h00,
      CFG_RESERVED      = 8'h01
   } cfg_addr_e;

   typedef enum logic {
      BURST_IDLE,
      BURST_ISSUE
   } burst_state_e;

endpackage

/* hw/free_list.sv */
module free_list #(
   parameter int LOG_DEPTH = 2
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 put,
   input  logic [LOG_DEPTH-1:0] put_id,
   input  logic                 take,
   output logic [LOG_DEPTH-1:0] next_id,
   output logic                 empty,
   output logic                 full
);
   localparam int DEPTH = 2 ** LOG_DEPTH;

   logic [LOG_DEPTH-1:0] ids [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;
   logic [LOG_DEPTH:0]   count;
   logic                 take_ok;

   assign take_ok = take && !empty;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= i[LOG_DEPTH-1:0];   // every id starts at home
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= DEPTH[LOG_DEPTH:0];
      end else begin
         if (take_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (put) begin
            ids[wr_ptr] <= put_id;   // returns may come back in any order
            wr_ptr      <= wr_ptr + 1'b1;
         end
         count <= count + put - take_ok;
      end
   end

   assign next_id = ids[rd_ptr];
   assign empty   = (count == '0);
   assign full    = (count == DEPTH[LOG_DEPTH:0]);

endmodule

/* hw/edge_addr_gen.sv */
`include "sssp_defs.svh"

module edge_addr_gen import sssp_pkg::*; (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    cfg_wvalid,
   input  cfg_addr_e               cfg_waddr,
   input  logic [`SSSP_WORD_W-1:0] cfg_wdata,
   input  parent_t                 parent,
   output logic [`SSSP_ADDR_W-1:0] rd_addr,
   output logic [7:0]              rd_words,
   output logic                    nonempty
);
   logic [`SSSP_ADDR_W-1:0] neighbor_base;
   logic [`SSSP_WORD_W-1:0] edge_cnt;
   logic [`SSSP_WORD_W-1:0] word_cnt;

   // base is written in word units
   always_ff @(posedge clk) begin
      if (!rstn) begin
         neighbor_base <= '0;
      end else if (cfg_wvalid && cfg_waddr == CFG_NEIGHBOR_BASE) begin
         neighbor_base <= {cfg_wdata[`SSSP_ADDR_W-3:0], 2'b00};
      end
   end

   assign edge_cnt = parent.eo_end - parent.eo_begin;
   assign word_cnt = edge_cnt * `SSSP_EDGE_WORDS;

   // 8 bytes per edge entry
   assign rd_addr  = neighbor_base + {parent.eo_begin[`SSSP_ADDR_W-4:0], 3'b000};
   assign rd_words = word_cnt[7:0];
   assign nonempty = (parent.eo_end != parent.eo_begin);   // only emptiness test

endmodule

/* hw/burst_splitter.sv */
`include "sssp_defs.svh"

module burst_splitter import sssp_pkg::*; (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    task_in_valid,
   output logic                    task_in_ready,
   input  parent_t                 parent,
   input  logic [`SSSP_ADDR_W-1:0] rd_addr,
   input  logic [7:0]              rd_words,
   input  logic                    nonempty,
   input  logic                    thread_empty,
   input  thread_id_t              thread_next,
   output logic                    thread_take,
   output thread_alloc_t           thread_alloc,
   input  logic                    arid_empty,
   input  arid_t                   arid_next,
   output logic                    arid_take,
   output rd_rec_wr_t              rec_wr,
   output logic                    arvalid,
   input  logic                    arready,
   output logic [`SSSP_ADDR_W-1:0] araddr,
   output arid_t                   arid
);
   localparam int OFF_W       = $clog2(`SSSP_LINE_WORDS);
   localparam int LINE_BYTE_W = OFF_W + 2;
   localparam logic [OFF_W:0] LINE_WORDS_V = `SSSP_LINE_WORDS;

   burst_state_e            state;
   logic [`SSSP_ADDR_W-1:0] cur_addr;
   logic [7:0]              words_left;
   thread_id_t              cur_thread;

   logic [OFF_W-1:0] line_off;
   logic [OFF_W:0]   room;
   logic [OFF_W:0]   burst_words;
   logic [OFF_W:0]   burst_end;
   logic [7:0]       room_w;
   logic             last_burst;
   logic             ar_fire;
   logic             accept;

   assign line_off    = cur_addr[LINE_BYTE_W-1:2];
   assign room        = LINE_WORDS_V - {1'b0, line_off};   // words to end of line
   assign room_w      = {{(8-OFF_W-1){1'b0}}, room};
   assign last_burst  = (words_left <= room_w);
   assign burst_words = last_burst ? words_left[OFF_W:0] : room;
   assign burst_end   = {1'b0, line_off} + burst_words;

   assign arvalid = (state == BURST_ISSUE) && !arid_empty;
   assign ar_fire = arvalid && arready;
   assign araddr  = cur_addr;
   assign arid    = arid_next;

   // empty parents pass straight through
   assign task_in_ready = !nonempty ||
                          (!thread_empty && (state == BURST_IDLE || (ar_fire && last_burst)));
   assign accept        = task_in_valid && task_in_ready && nonempty;

   assign thread_take = accept;
   assign arid_take   = ar_fire;

   always_comb begin
      thread_alloc.valid       = accept;
      thread_alloc.thread      = thread_next;
      thread_alloc.parent_task = parent.task_desc;
      thread_alloc.n_words     = rd_words;
   end

   always_comb begin
      rec_wr.valid      = ar_fire;
      rec_wr.id         = arid_next;
      rec_wr.rec.thread = cur_thread;
      for (int i = 0; i < `SSSP_LINE_WORDS; i++) begin
         rec_wr.rec.valid_words[i] = (i >= line_off) && (i < burst_end);
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= BURST_IDLE;
      end else if (accept) begin
         state <= BURST_ISSUE;
      end else if (ar_fire && last_burst) begin
         state <= BURST_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= rd_addr;
         words_left <= rd_words;
         cur_thread <= thread_next;
      end else if (ar_fire) begin
         // next request starts on the following line
         cur_addr   <= {cur_addr[`SSSP_ADDR_W-1:LINE_BYTE_W] + 1'b1, {LINE_BYTE_W{1'b0}}};
         words_left <= words_left - room_w;
      end
   end

endmodule

/* hw/line_unpacker.sv */
`include "sssp_defs.svh"

module line_unpacker import sssp_pkg::*; (
   input  logic                    clk,
   input  logic                    rstn,
   input  rd_rec_wr_t              rec_wr,
   input  thread_alloc_t           thread_alloc,
   input  logic                    rvalid,
   output logic                    rready,
   input  arid_t                   rid,
   input  logic [`SSSP_LINE_W-1:0] rdata,
   output logic                    arid_release,
   output arid_t                   release_id,
   output logic                    thread_release,
   output thread_id_t              release_thread,
   output logic                    edge_valid,
   input  logic                    edge_ready,
   output child_t                  edge_child
);
   localparam int N_THREADS = 2 ** `SSSP_LOG_THREADS;
   localparam int N_ARIDS   = 2 ** `SSSP_LOG_ARIDS;
   localparam int PAIRS     = `SSSP_LINE_WORDS / `SSSP_EDGE_WORDS;
   localparam int PAIR_W    = $clog2(PAIRS);
   localparam int EDGE_W    = `SSSP_WORD_W * `SSSP_EDGE_WORDS;

   rd_rec_t rd_tab [N_ARIDS];
   task_t   thr_task [N_THREADS];
   logic [7:0] thr_left [N_THREADS];   // words not yet turned into edges

   logic                    held;
   rd_rec_t                 held_rec;
   logic [`SSSP_LINE_W-1:0] held_data;

   logic [PAIR_W-1:0]          pair_idx;
   logic [`SSSP_LINE_WORDS-1:0] pair_mask;
   logic [`SSSP_LINE_WORDS-1:0] next_valid;
   logic [`SSSP_WORD_W-1:0]    nbr_word;
   logic [`SSSP_WORD_W-1:0]    wgt_word;
   logic                       r_fire;
   logic                       e_fire;

   always_ff @(posedge clk) begin
      if (rec_wr.valid) begin
         rd_tab[rec_wr.id] <= rec_wr.rec;
      end
   end

   assign rready       = !held;
   assign r_fire       = rvalid && rready;
   assign arid_release = r_fire;
   assign release_id   = rid;

   // lowest valid pair first; entries are pair aligned
   always_comb begin
      pair_idx = '0;
      for (int p = PAIRS - 1; p >= 0; p--) begin
         if (held_rec.valid_words[p*`SSSP_EDGE_WORDS]) begin
            pair_idx = p[PAIR_W-1:0];
         end
      end
   end

   assign pair_mask  = {{(`SSSP_LINE_WORDS-2){1'b0}}, 2'b11} << (pair_idx * `SSSP_EDGE_WORDS);
   assign next_valid = held_rec.valid_words & ~pair_mask;
   assign nbr_word   = held_data[pair_idx*EDGE_W +: `SSSP_WORD_W];
   assign wgt_word   = held_data[pair_idx*EDGE_W + `SSSP_WORD_W +: `SSSP_WORD_W];

   assign edge_valid = held;
   assign e_fire     = edge_valid && edge_ready;

   always_comb begin
      edge_child.child_task.ts     = thr_task[held_rec.thread].ts + wgt_word;
      edge_child.child_task.vertex = nbr_word;
      edge_child.last = (thr_left[held_rec.thread] == `SSSP_EDGE_WORDS);
   end

   assign thread_release = e_fire && edge_child.last;
   assign release_thread = held_rec.thread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         held <= 1'b0;
      end else if (r_fire) begin
         held <= 1'b1;
      end else if (e_fire && next_valid == '0) begin
         held <= 1'b0;   // last pair of the line has gone
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         held_rec  <= rd_tab[rid];
         held_data <= rdata;
      end else if (e_fire) begin
         held_rec.valid_words <= next_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (thread_alloc.valid) begin
         thr_task[thread_alloc.thread] <= thread_alloc.parent_task;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int t = 0; t < N_THREADS; t++) begin
            thr_left[t] <= '0;
         end
      end else begin
         for (int t = 0; t < N_THREADS; t++) begin
            if (thread_alloc.valid && thread_alloc.thread == t) begin
               thr_left[t] <= thread_alloc.n_words;
            end else if (e_fire && held_rec.thread == t) begin
               thr_left[t] <= thr_left[t] - `SSSP_EDGE_WORDS;
            end
         end
      end
   end

endmodule

/* hw/child_gen.sv */
module child_gen import sssp_pkg::*; (
   input  logic   clk,
   input  logic   rstn,
   input  logic   edge_valid,
   output logic   edge_ready,
   input  child_t edge_child,
   output logic   out_valid,
   input  logic   out_ready,
   output child_t out_child
);
   logic take;

   // refill in the same cycle the current child leaves
   assign edge_ready = !out_valid || out_ready;
   assign take       = edge_valid && edge_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         out_valid <= 1'b0;
      end else if (take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         out_child <= edge_child;
      end
   end

endmodule

/* hw/neighbor_read_stage.sv */
`include "sssp_defs.svh"

module neighbor_read_stage import sssp_pkg::*; (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    task_in_valid,
   output logic                    task_in_ready,
   input  parent_t                 in_task,
   output logic                    arvalid,
   input  logic                    arready,
   output logic [`SSSP_ADDR_W-1:0] araddr,
   output arid_t                   arid,
   input  logic                    rvalid,
   output logic                    rready,
   input  arid_t                   rid,
   input  logic [`SSSP_LINE_W-1:0] rdata,
   output logic                    out_valid,
   input  logic                    out_ready,
   output child_t                  out_child,
   input  logic                    cfg_wvalid,
   input  cfg_addr_e               cfg_waddr,
   input  logic [`SSSP_WORD_W-1:0] cfg_wdata,
   output logic                    idle
);
   logic [`SSSP_ADDR_W-1:0] rd_addr;
   logic [7:0]              rd_words;
   logic                    nonempty;
   logic                    thread_empty, thread_take, thread_release;
   thread_id_t              thread_next, release_thread;
   thread_alloc_t           thread_alloc;
   logic                    arid_empty, arid_take, arid_release;
   arid_t                   arid_next, release_id;
   rd_rec_wr_t              rec_wr;
   logic                    edge_valid, edge_ready;
   child_t                  edge_child;

   edge_addr_gen i_addr_gen (.clk, .rstn, .cfg_wvalid, .cfg_waddr, .cfg_wdata,
      .parent(in_task), .rd_addr, .rd_words, .nonempty);

   burst_splitter i_splitter (.clk, .rstn, .task_in_valid, .task_in_ready,
      .parent(in_task), .rd_addr, .rd_words, .nonempty, .thread_empty, .thread_next,
      .thread_take, .thread_alloc, .arid_empty, .arid_next, .arid_take, .rec_wr,
      .arvalid, .arready, .araddr, .arid);

   line_unpacker i_unpacker (.clk, .rstn, .rec_wr, .thread_alloc, .rvalid, .rready,
      .rid, .rdata, .arid_release, .release_id, .thread_release, .release_thread,
      .edge_valid, .edge_ready, .edge_child);

   child_gen i_child_gen (.clk, .rstn, .edge_valid, .edge_ready, .edge_child,
      .out_valid, .out_ready, .out_child);

   free_list #(.LOG_DEPTH(`SSSP_LOG_ARIDS)) arid_pool (.clk, .rstn,
      .put(arid_release), .put_id(release_id), .take(arid_take),
      .next_id(arid_next), .empty(arid_empty), .full());

   // all threads home means nothing is in flight
   free_list #(.LOG_DEPTH(`SSSP_LOG_THREADS)) thread_pool (.clk, .rstn,
      .put(thread_release), .put_id(release_thread), .take(thread_take),
      .next_id(thread_next), .empty(thread_empty), .full(idle));

endmodule

/* dv/clk_gen.sv */
module clk_gen #(
   parameter int PERIOD     = 20,
   parameter int RST_CYCLES = 8
) (
   output logic clk,
   output logic rstn
);
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   initial begin
      rstn = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rstn = 1'b1;   // released just after an edge like every other input
   end

endmodule

/* dv/sssp_assertions.sv */
`include "sssp_defs.svh"

module sssp_assertions import sssp_pkg::*; (
   input logic                    clk,
   input logic                    rstn,
   input logic                    arvalid,
   input logic                    arready,
   input logic [`SSSP_ADDR_W-1:0] araddr,
   input arid_t                   arid,
   input logic                    rvalid,
   input logic                    rready,
   input logic                    out_valid,
   input logic                    out_ready,
   input child_t                  out_child
);
   int unsigned n_fail = 0;
   int unsigned n_reads;   // requests sent but not yet answered

   always_ff @(posedge clk) begin
      if (!rstn) begin
         n_reads <= 0;
      end else begin
         n_reads <= n_reads + (arvalid && arready) - (rvalid && rready);
      end
   end

   ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
      else begin
         n_fail++;
         $error("read request dropped or changed before arready");
      end

   out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_child))
      else begin
         n_fail++;
         $error("child dropped or changed before out_ready");
      end

   no_stray_resp: assert property (@(posedge clk) disable iff (!rstn)
      rvalid |-> n_reads != 0)
      else begin
         n_fail++;
         $error("response seen with no read outstanding");
      end

endmodule

bind neighbor_read_stage sssp_assertions i_sva (
   .clk(clk), .rstn(rstn), .arvalid(arvalid), .arready(arready), .araddr(araddr),
   .arid(arid), .rvalid(rvalid), .rready(rready), .out_valid(out_valid),
   .out_ready(out_ready), .out_child(out_child)
);

/* dv/sssp_checker.sv */
`include "sssp_defs.svh"

module sssp_checker import sssp_pkg::*; (
   input logic                    clk,
   input logic                    rstn,
   input logic                    task_in_valid,
   input logic                    task_in_ready,
   input parent_t                 in_task,
   input logic                    arvalid,
   input logic                    arready,
   input logic [`SSSP_ADDR_W-1:0] araddr,
   input arid_t                   arid,
   input logic                    rvalid,
   input logic                    rready,
   input arid_t                   rid,
   input logic                    out_valid,
   input logic                    out_ready,
   input child_t                  out_child,
   input logic                    idle
);
   localparam int N_ARIDS = 2 ** `SSSP_LOG_ARIDS;

   child_t                  exp_child_q [$];
   logic [`SSSP_ADDR_W-1:0] exp_addr_q [$];
   int   err_child  = 0;
   int   err_addr   = 0;
   int   err_other  = 0;
   int   n_children = 0;
   int   in_flight  = 0;   // children of accepted parents not yet out
   logic [N_ARIDS-1:0] ids_out = '0;   // ids with a request but no response yet

   function automatic void add_child(input child_t c);
      exp_child_q.push_back(c);
   endfunction

   function automatic void add_addr(input logic [`SSSP_ADDR_W-1:0] a);
      exp_addr_q.push_back(a);
   endfunction

   function automatic int pending();
      return exp_child_q.size() + exp_addr_q.size();
   endfunction

   initial begin : idle_after_reset
      @(posedge rstn);
      @(posedge clk);
      if (idle !== 1'b1) begin
         err_other++;
         $display("FAILED %0t: idle is low right after reset", $time);
      end
   end

   always @(posedge clk) begin : compare
      child_t                  exp_c;
      logic [`SSSP_ADDR_W-1:0] exp_a;
      if (rstn) begin
         // all slots home leaves at most the last child in the output register
         if (idle && in_flight > (out_valid ? 1 : 0)) begin
            err_other++;
            $display("FAILED %0t: idle is high while a parent is in flight", $time);
         end
         if (task_in_valid && task_in_ready) begin
            in_flight += in_task.eo_end - in_task.eo_begin;
         end
         if (out_valid && out_ready) begin
            n_children++;
            in_flight--;
            if (exp_child_q.size() == 0) begin
               err_other++;
               $display("child vertex %h came out at %0t with nothing expected",
                        out_child.child_task.vertex, $time);
            end else begin
               exp_c = exp_child_q.pop_front();
               if (out_child !== exp_c) begin
                  err_child++;
                  $display("FAILED %0t: child ts %h vtx %h last %b, expected ts %h vtx %h last %b",
                           $time, out_child.child_task.ts, out_child.child_task.vertex,
                           out_child.last, exp_c.child_task.ts, exp_c.child_task.vertex,
                           exp_c.last);
               end
            end
         end
         if (rvalid && rready) begin
            ids_out[rid] = 1'b0;
         end
         if (arvalid && arready) begin
            if (ids_out[arid]) begin
               err_other++;
               $display("FAILED %0t: read id %0d reused while still outstanding",
                        $time, arid);
            end
            ids_out[arid] = 1'b1;
            if (exp_addr_q.size() == 0) begin
               err_other++;
               $display("read request to %h at %0t with none expected", araddr, $time);
            end else begin
               exp_a = exp_addr_q.pop_front();
               if (araddr !== exp_a) begin
                  err_addr++;
                  $display("FAILED %0t: read address %h, expected %h", $time, araddr, exp_a);
               end
            end
         end
      end else begin
         in_flight = 0;
         ids_out   = '0;
      end
   end

endmodule

/* dv/sssp_tb.sv */
`include "sssp_defs.svh"

module sssp_tb import sssp_pkg::*; ();
   localparam int N_RAND_PARENTS = 60;
   localparam int MAX_EDGES      = 24;
   localparam int TIMEOUT_CYCLES = 20000;   // 60 parents x 24 edges under stalls, with margin

   logic                    clk;
   logic                    rstn;
   logic                    task_in_valid;
   logic                    task_in_ready;
   parent_t                 in_task;
   logic                    arvalid;
   logic                    arready;
   logic [`SSSP_ADDR_W-1:0] araddr;
   arid_t                   arid;
   logic                    rvalid;
   logic                    rready;
   arid_t                   rid;
   logic [`SSSP_LINE_W-1:0] rdata;
   logic                    out_valid;
   logic                    out_ready;
   child_t                  out_child;
   logic                    cfg_wvalid;
   cfg_addr_e               cfg_waddr;
   logic [`SSSP_WORD_W-1:0] cfg_wdata;
   logic                    idle;

   integer                  seed = 32'hd73455d3;
   logic                    stalls = 1'b0;
   logic [`SSSP_ADDR_W-1:0] nbr_base = '0;   // testbench copy of the base register
   int                      n_expected = 0;
   int                      cycles;

   clk_gen #(.PERIOD(20), .RST_CYCLES(8)) i_clk (.clk(clk), .rstn(rstn));

   neighbor_read_stage i_dut (.clk, .rstn, .task_in_valid, .task_in_ready, .in_task,
      .arvalid, .arready, .araddr, .arid, .rvalid, .rready, .rid, .rdata,
      .out_valid, .out_ready, .out_child, .cfg_wvalid, .cfg_waddr, .cfg_wdata, .idle);

   sssp_checker i_chk (.clk, .rstn, .task_in_valid, .task_in_ready, .in_task,
      .arvalid, .arready, .araddr, .arid, .rvalid, .rready, .rid, .out_valid, .out_ready,
      .out_child, .idle);

   function automatic logic [`SSSP_WORD_W-1:0] mem_word(input logic [`SSSP_ADDR_W-1:0] a);
      return (a * 32'h9e3779b1) ^ 32'h5a5a0000;
   endfunction

   function automatic logic [`SSSP_LINE_W-1:0] line_at(input logic [`SSSP_ADDR_W-1:0] a);
      logic [`SSSP_LINE_W-1:0] line;
      logic [`SSSP_ADDR_W-1:0] lb;
      lb = {a[`SSSP_ADDR_W-1:6], 6'd0};
      for (int i = 0; i < `SSSP_LINE_WORDS; i++) begin
         line[i*`SSSP_WORD_W +: `SSSP_WORD_W] = mem_word(lb + 4 * i);
      end
      return line;
   endfunction

   // edge k sits at base + 8 * (eo_begin + k) as neighbour word then weight word
   function automatic child_t ref_child(input parent_t p, input logic [31:0] base, input int k);
      logic [`SSSP_ADDR_W-1:0] a;
      child_t                  c;
      a = base + 8 * (p.eo_begin + k);
      c.child_task.vertex = mem_word(a);
      c.child_task.ts     = p.task_desc.ts + mem_word(a + 4);
      c.last              = (k == p.eo_end - p.eo_begin - 1);
      return c;
   endfunction

   function automatic parent_t make_parent(input logic [31:0] ts, input logic [31:0] vtx,
                                           input logic [31:0] eb, input logic [31:0] ee);
      parent_t p;
      p.task_desc.ts     = ts;
      p.task_desc.vertex = vtx;
      p.eo_begin         = eb;
      p.eo_end           = ee;
      return p;
   endfunction

   task automatic expect_parent(input parent_t p);
      int                      n_words;
      int                      room;
      logic [`SSSP_ADDR_W-1:0] a;
      n_words = 2 * (p.eo_end - p.eo_begin);
      for (int k = 0; k < n_words / 2; k++) begin
         i_chk.add_child(ref_child(p, nbr_base, k));
      end
      n_expected += n_words / 2;
      a = nbr_base + 8 * p.eo_begin;
      while (n_words > 0) begin
         i_chk.add_addr(a);
         room    = `SSSP_LINE_WORDS - a[5:2];
         n_words -= room;
         a       = {a[`SSSP_ADDR_W-1:6] + 1'b1, 6'd0};   // later requests are line aligned
      end
   endtask

   task automatic send_parent(input parent_t p);
      expect_parent(p);
      task_in_valid = 1'b1;
      in_task       = p;
      do @(posedge clk); while (!task_in_ready);
      #1;
      task_in_valid = 1'b0;
   endtask

   task automatic write_cfg(input cfg_addr_e addr, input logic [31:0] data);
      cfg_wvalid = 1'b1;
      cfg_waddr  = addr;
      cfg_wdata  = data;
      @(posedge clk);
      #1;
      cfg_wvalid = 1'b0;
      if (addr == CFG_NEIGHBOR_BASE) begin
         nbr_base = data << 2;   // word units
      end
   endtask

   task automatic wait_drained();
      do @(posedge clk); while (!(idle && !out_valid && i_chk.pending() == 0));
      #1;
   endtask

   initial begin : ready_drive
      arready   = 1'b1;
      out_ready = 1'b1;
      forever begin
         @(posedge clk);
         #1;
         arready   = !stalls || (($random(seed) & 3) != 0);
         out_ready = !stalls || (($random(seed) & 1) != 0);
      end
   end

   // answers in request order after 0 to 3 idle cycles
   initial begin : mem_model
      logic [`SSSP_ADDR_W-1:0] addr_q [$];
      arid_t                   id_q [$];
      logic                    ar_hit;
      logic                    r_hit;
      logic [`SSSP_ADDR_W-1:0] a_s;
      arid_t                   id_s;
      int                      delay;
      rvalid = 1'b0;
      rid    = '0;
      rdata  = '0;
      delay  = 0;
      forever begin
         @(posedge clk);
         ar_hit = arvalid && arready;
         r_hit  = rvalid && rready;
         a_s    = araddr;
         id_s   = arid;
         #1;
         if (ar_hit) begin
            addr_q.push_back(a_s);
            id_q.push_back(id_s);
         end
         if (r_hit) begin
            rvalid = 1'b0;
         end
         if (!rvalid && addr_q.size() > 0) begin
            if (delay > 0) begin
               delay--;
            end else begin
               rdata  = line_at(addr_q.pop_front());
               rid    = id_q.pop_front();
               rvalid = 1'b1;
               delay  = $random(seed) & 3;
            end
         end
      end
   end

   initial begin : watchdog
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

   initial begin : stimulus
      logic [31:0] eb;
      int          n_edges;
      int          count_err;
      int          total;
      task_in_valid = 1'b0;
      in_task       = '0;
      cfg_wvalid    = 1'b0;
      cfg_waddr     = CFG_NEIGHBOR_BASE;
      cfg_wdata     = '0;
      count_err     = 0;
      @(posedge rstn);
      @(posedge clk);
      #1;
      write_cfg(CFG_NEIGHBOR_BASE, 32'h0000_1000);
      send_parent(make_parent(32'h100, 32'h7, 2, 6));    // inside one line
      send_parent(make_parent(32'h200, 32'h8, 5, 27));   // spans four lines
      send_parent(make_parent(32'h300, 32'h9, 9, 9));    // empty range
      wait_drained();

      // new base, reserved address must not touch it
      write_cfg(CFG_NEIGHBOR_BASE, 32'h0000_2346);
      write_cfg(CFG_RESERVED, 32'hdead_0001);
      send_parent(make_parent(32'h400, 32'ha, 3, 13));
      wait_drained();

      stalls = 1'b1;
      for (int i = 0; i < N_RAND_PARENTS; i++) begin
         n_edges = $unsigned($random(seed)) % (MAX_EDGES + 1);
         eb      = $random(seed) & 32'h3ff;
         send_parent(make_parent($random(seed), $random(seed), eb, eb + n_edges));
      end
      wait_drained();

      if (i_chk.n_children != n_expected) begin
         count_err++;
         $display("saw %0d children but %0d were expected", i_chk.n_children, n_expected);
      end
      total = i_chk.err_child + i_chk.err_addr + i_chk.err_other + count_err
              + i_dut.i_sva.n_fail;
      $display("errors: %0d child, %0d address, %0d other, %0d assertion",
               i_chk.err_child, i_chk.err_addr, i_chk.err_other + count_err,
               i_dut.i_sva.n_fail);
      if (total == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* compile.f */
+incdir+hw
hw/sssp_pkg.sv
hw/free_list.sv
hw/edge_addr_gen.sv
hw/burst_splitter.sv
hw/line_unpacker.sv
hw/child_gen.sv
hw/neighbor_read_stage.sv
dv/clk_gen.sv
dv/sssp_assertions.sv
dv/sssp_checker.sv
dv/sssp_tb.sv
